// ==== hdl/uart_mon_pkg.sv ====
package uart_mon_pkg;

	// one serial character
	typedef logic [7:0] byte_t;

	// one memory word
	typedef logic [31:0] word_t;

	// word address, byte address bits 13:2
	typedef logic [11:0] mem_adr_t;

	// operation handed from the parser to memory access
	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_GO,
		OP_QUIT
	} mon_op_e;

	// reply kind handed from the parser to the formatter
	typedef enum logic [1:0] {
		REPLY_WORD,
		REPLY_OK,
		REPLY_ERR
	} reply_e;

	localparam byte_t CHAR_CR    = 8'h0d;
	localparam byte_t CHAR_LF    = 8'h0a;
	localparam byte_t CHAR_SPACE = 8'h20;

endpackage

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                clk,
	input  logic                i_reset,
	input  logic                i_rx,
	output uart_mon_pkg::byte_t o_data,
	output logic                o_valid
);

	import uart_mon_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	// the two synchronizer stages are already part of the half bit
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e        state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	byte_t            shift;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == HALF_LAST) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						// line back high at mid start bit means a glitch
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						shift   <= {rx_sync, shift[7:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						state   <= RX_IDLE;
						// framing error, byte is lost
						if (rx_sync) begin
							o_valid <= 1'b1;
							o_data  <= shift;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// one frame never yields two bytes
	a_valid_single: assert property (@(posedge clk) disable iff (i_reset)
		o_valid |=> !o_valid);

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                clk,
	input  logic                i_reset,
	input  logic                i_req,
	input  uart_mon_pkg::byte_t i_data,
	output logic                o_ack,
	output logic                o_tx
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_SHIFT,
		TX_ACK
	} tx_state_e;

	tx_state_e        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [3:0]       bit_cnt;
	// data bits then stop bit
	logic [8:0]       frame;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			o_ack   <= 1'b0;
			o_tx    <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					if (i_req) begin
						frame   <= {1'b1, i_data};
						o_tx    <= 1'b0;
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= TX_SHIFT;
					end
				end
				TX_SHIFT: begin
					if (clk_cnt == BIT_LAST) begin
						clk_cnt <= '0;
						if (bit_cnt == 4'd9) begin
							// stop bit done
							o_ack <= 1'b1;
							state <= TX_ACK;
						end else begin
							o_tx    <= frame[0];
							frame   <= {1'b1, frame[8:1]};
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (!i_req) begin
						o_ack <= 1'b0;
						state <= TX_IDLE;
					end
				end
			endcase
		end
	end

	// sender must hold the byte until the frame is out
	a_data_stable: assert property (@(posedge clk) disable iff (i_reset)
		(i_req && !o_ack) |=> (o_ack || $stable(i_data)));

endmodule

// ==== hdl/mon_cmd_parser.sv ====
`timescale 1ns/1ps

module mon_cmd_parser (
	input  logic                   clk,
	input  logic                   i_reset,
	input  uart_mon_pkg::byte_t    i_rx_data,
	input  logic                   i_rx_valid,
	output logic                   o_op_req,
	input  logic                   i_op_ack,
	output uart_mon_pkg::mon_op_e  o_op,
	output uart_mon_pkg::mem_adr_t o_op_adr,
	output uart_mon_pkg::word_t    o_op_wdata,
	input  uart_mon_pkg::word_t    i_op_rdata,
	output logic                   o_rep_req,
	input  logic                   i_rep_ack,
	output uart_mon_pkg::reply_e   o_rep_kind,
	output uart_mon_pkg::word_t    o_rep_word
);

	import uart_mon_pkg::*;

	typedef enum logic [3:0] {
		PS_CMD,
		PS_GAP1,
		PS_ADR,
		PS_GAP2,
		PS_DATA,
		PS_TRAIL,
		PS_OP,
		PS_OP_END,
		PS_REPLY,
		PS_REPLY_END
	} ps_state_e;

	ps_state_e  state;
	logic       err;
	word_t      acc;
	logic       is_hex;
	logic [3:0] nib;
	logic       line_bad;

	// hex digit decode, either case
	always_comb begin
		is_hex = 1'b1;
		nib    = 4'h0;
		if (i_rx_data >= "0" && i_rx_data <= "9")
			nib = 4'(i_rx_data - 8'h30);
		else if (i_rx_data >= "a" && i_rx_data <= "f")
			nib = 4'(i_rx_data - 8'h57);
		else if (i_rx_data >= "A" && i_rx_data <= "F")
			nib = 4'(i_rx_data - 8'h37);
		else
			is_hex = 1'b0;
	end

	// what a CR in the current state means
	always_comb begin
		case (state)
			PS_CMD:  line_bad = 1'b1;
			PS_GAP1: line_bad = err || (o_op != OP_QUIT);
			PS_ADR:  line_bad = err || (o_op == OP_WRITE);
			PS_GAP2: line_bad = 1'b1;
			default: line_bad = err;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state     <= PS_CMD;
			err       <= 1'b0;
			o_op_req  <= 1'b0;
			o_rep_req <= 1'b0;
		end else begin
			case (state)
				PS_OP: begin
					if (i_op_ack) begin
						o_rep_word <= i_op_rdata;
						o_op_req   <= 1'b0;
						state      <= PS_OP_END;
					end
				end
				PS_OP_END: begin
					if (!i_op_ack) begin
						o_rep_req <= 1'b1;
						state     <= PS_REPLY;
					end
				end
				PS_REPLY: begin
					// ack comes only after the last reply character
					if (i_rep_ack) begin
						o_rep_req <= 1'b0;
						state     <= PS_REPLY_END;
					end
				end
				PS_REPLY_END: begin
					if (!i_rep_ack) begin
						err   <= 1'b0;
						state <= PS_CMD;
					end
				end
				default: begin
					// input states only, LF is ignored
					if (i_rx_valid && i_rx_data != CHAR_LF) begin
						if (i_rx_data == CHAR_CR) begin
							if (state == PS_ADR)
								o_op_adr <= acc[11:0];
							if (state == PS_DATA)
								o_op_wdata <= acc;
							if (line_bad) begin
								o_rep_kind <= REPLY_ERR;
								o_rep_req  <= 1'b1;
								state      <= PS_REPLY;
							end else begin
								o_rep_kind <= (o_op == OP_READ) ? REPLY_WORD : REPLY_OK;
								o_op_req   <= 1'b1;
								state      <= PS_OP;
							end
						end else begin
							case (state)
								PS_CMD: begin
									state <= PS_GAP1;
									case (i_rx_data)
										"w": o_op <= OP_WRITE;
										"r": o_op <= OP_READ;
										"g": o_op <= OP_GO;
										"q": o_op <= OP_QUIT;
										default: begin
											err   <= 1'b1;
											state <= PS_TRAIL;
										end
									endcase
								end
								PS_GAP1: begin
									// quit takes no field
									if (is_hex && o_op != OP_QUIT) begin
										acc   <= word_t'(nib);
										state <= PS_ADR;
									end else if (i_rx_data != CHAR_SPACE) begin
										err   <= 1'b1;
										state <= PS_TRAIL;
									end
								end
								PS_ADR: begin
									if (is_hex) begin
										acc <= {acc[27:0], nib};
									end else if (i_rx_data == CHAR_SPACE) begin
										o_op_adr <= acc[11:0];
										state    <= (o_op == OP_WRITE) ? PS_GAP2 : PS_TRAIL;
									end else begin
										err   <= 1'b1;
										state <= PS_TRAIL;
									end
								end
								PS_GAP2: begin
									if (is_hex) begin
										acc   <= word_t'(nib);
										state <= PS_DATA;
									end else if (i_rx_data != CHAR_SPACE) begin
										err   <= 1'b1;
										state <= PS_TRAIL;
									end
								end
								PS_DATA: begin
									if (is_hex) begin
										acc <= {acc[27:0], nib};
									end else if (i_rx_data == CHAR_SPACE) begin
										o_op_wdata <= acc;
										state      <= PS_TRAIL;
									end else begin
										err   <= 1'b1;
										state <= PS_TRAIL;
									end
								end
								default: begin
									// anything past the last field is one too many
									if (i_rx_data != CHAR_SPACE)
										err <= 1'b1;
								end
							endcase
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== hdl/mon_mem_access.sv ====
`timescale 1ns/1ps

module mon_mem_access (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic                   i_op_req,
	input  uart_mon_pkg::mon_op_e  i_op,
	input  uart_mon_pkg::mem_adr_t i_op_adr,
	input  uart_mon_pkg::word_t    i_op_wdata,
	output logic                   o_op_ack,
	output uart_mon_pkg::word_t    o_op_rdata,
	output uart_mon_pkg::mem_adr_t o_ram_adr,
	output uart_mon_pkg::word_t    o_ram_wdata,
	input  uart_mon_pkg::word_t    i_ram_rdata,
	output logic                   o_ram_wen,
	output logic                   o_cpu_start,
	output logic                   o_quit,
	output uart_mon_pkg::mem_adr_t o_start_adr
);

	import uart_mon_pkg::*;

	typedef enum logic [1:0] {
		MA_IDLE,
		MA_STEP,
		MA_READ,
		MA_ACK
	} ma_state_e;

	ma_state_e state;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state       <= MA_IDLE;
			o_op_ack    <= 1'b0;
			o_ram_adr   <= '0;
			o_ram_wen   <= 1'b0;
			o_cpu_start <= 1'b0;
			o_quit      <= 1'b0;
			o_start_adr <= '0;
		end else begin
			case (state)
				MA_IDLE: begin
					if (i_op_req) begin
						o_ram_adr   <= i_op_adr;
						o_ram_wdata <= i_op_wdata;
						case (i_op)
							OP_WRITE: o_ram_wen <= 1'b1;
							OP_GO: begin
								o_start_adr <= i_op_adr;
								o_cpu_start <= 1'b1;
							end
							OP_QUIT: o_quit <= 1'b1;
							// read only needs the address
							default: ;
						endcase
						state <= MA_STEP;
					end
				end
				MA_STEP: begin
					o_ram_wen   <= 1'b0;
					o_cpu_start <= 1'b0;
					o_quit      <= 1'b0;
					if (i_op == OP_READ) begin
						state <= MA_READ;
					end else begin
						o_op_ack <= 1'b1;
						state    <= MA_ACK;
					end
				end
				MA_READ: begin
					// ram data is valid one cycle after the address
					o_op_rdata <= i_ram_rdata;
					o_op_ack   <= 1'b1;
					state      <= MA_ACK;
				end
				default: begin
					if (!i_op_req) begin
						o_op_ack <= 1'b0;
						state    <= MA_IDLE;
					end
				end
			endcase
		end
	end

	a_ack_in_req: assert property (@(posedge clk) disable iff (i_reset)
		$rose(o_op_ack) |-> i_op_req);

	a_wen_pulse: assert property (@(posedge clk) disable iff (i_reset)
		$rose(o_ram_wen) |=> !o_ram_wen);

endmodule

// ==== hdl/mon_reply.sv ====
`timescale 1ns/1ps

module mon_reply (
	input  logic                 clk,
	input  logic                 i_reset,
	input  logic                 i_rep_req,
	input  uart_mon_pkg::reply_e i_rep_kind,
	input  uart_mon_pkg::word_t  i_rep_word,
	output logic                 o_rep_ack,
	output logic                 o_tx_req,
	input  logic                 i_tx_ack,
	output uart_mon_pkg::byte_t  o_tx_data
);

	import uart_mon_pkg::*;

	typedef enum logic [1:0] {
		RP_IDLE,
		RP_SEND,
		RP_GAP,
		RP_DONE
	} rp_state_e;

	rp_state_e  state;
	logic [3:0] char_idx;
	logic [3:0] body_len;
	logic [3:0] nibble;

	// nibble to upper case ascii
	function automatic byte_t hex_char(input logic [3:0] n);
		if (n < 4'd10)
			return 8'h30 + 8'(n);
		return 8'h37 + 8'(n);
	endfunction

	always_comb begin
		case (i_rep_kind)
			REPLY_WORD: body_len = 4'd8;
			REPLY_OK:   body_len = 4'd2;
			default:    body_len = 4'd1;
		endcase
		// most significant nibble first
		nibble = i_rep_word[31 - 4 * char_idx[2:0] -: 4];
		if (char_idx == body_len)
			o_tx_data = CHAR_CR;
		else if (char_idx > body_len)
			o_tx_data = CHAR_LF;
		else if (i_rep_kind == REPLY_WORD)
			o_tx_data = hex_char(nibble);
		else if (i_rep_kind == REPLY_OK)
			o_tx_data = (char_idx == 4'd0) ? "O" : "K";
		else
			o_tx_data = "?";
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state     <= RP_IDLE;
			char_idx  <= '0;
			o_rep_ack <= 1'b0;
			o_tx_req  <= 1'b0;
		end else begin
			case (state)
				RP_IDLE: begin
					if (i_rep_req) begin
						char_idx <= '0;
						o_tx_req <= 1'b1;
						state    <= RP_SEND;
					end
				end
				RP_SEND: begin
					if (i_tx_ack) begin
						o_tx_req <= 1'b0;
						state    <= RP_GAP;
					end
				end
				RP_GAP: begin
					if (!i_tx_ack) begin
						// LF sits right after CR
						if (char_idx == body_len + 4'd1) begin
							o_rep_ack <= 1'b1;
							state     <= RP_DONE;
						end else begin
							char_idx <= char_idx + 1'b1;
							o_tx_req <= 1'b1;
							state    <= RP_SEND;
						end
					end
				end
				default: begin
					if (!i_rep_req) begin
						o_rep_ack <= 1'b0;
						state     <= RP_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== hdl/uart_mon_top.sv ====
`timescale 1ns/1ps

module uart_mon_top #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                   clk,
	input  logic                   i_reset,
	input  logic                   i_rx,
	output logic                   o_tx,
	output uart_mon_pkg::mem_adr_t o_ram_adr,
	output uart_mon_pkg::word_t    o_ram_wdata,
	input  uart_mon_pkg::word_t    i_ram_rdata,
	output logic                   o_ram_wen,
	output logic                   o_cpu_start,
	output logic                   o_quit,
	output uart_mon_pkg::mem_adr_t o_start_adr
);

	import uart_mon_pkg::*;

	byte_t    rx_data;
	logic     rx_valid;
	logic     op_req;
	logic     op_ack;
	mon_op_e  op;
	mem_adr_t op_adr;
	word_t    op_wdata;
	word_t    op_rdata;
	logic     rep_req;
	logic     rep_ack;
	reply_e   rep_kind;
	word_t    rep_word;
	logic     tx_req;
	logic     tx_ack;
	byte_t    tx_data;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_rx_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.o_data(rx_data),
		.o_valid(rx_valid)
	);

	mon_cmd_parser mon_cmd_parser_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_rx_data(rx_data),
		.i_rx_valid(rx_valid),
		.o_op_req(op_req),
		.i_op_ack(op_ack),
		.o_op(op),
		.o_op_adr(op_adr),
		.o_op_wdata(op_wdata),
		.i_op_rdata(op_rdata),
		.o_rep_req(rep_req),
		.i_rep_ack(rep_ack),
		.o_rep_kind(rep_kind),
		.o_rep_word(rep_word)
	);

	mon_mem_access mon_mem_access_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_op_req(op_req),
		.i_op(op),
		.i_op_adr(op_adr),
		.i_op_wdata(op_wdata),
		.o_op_ack(op_ack),
		.o_op_rdata(op_rdata),
		.o_ram_adr(o_ram_adr),
		.o_ram_wdata(o_ram_wdata),
		.i_ram_rdata(i_ram_rdata),
		.o_ram_wen(o_ram_wen),
		.o_cpu_start(o_cpu_start),
		.o_quit(o_quit),
		.o_start_adr(o_start_adr)
	);

	mon_reply mon_reply_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_rep_req(rep_req),
		.i_rep_kind(rep_kind),
		.i_rep_word(rep_word),
		.o_rep_ack(rep_ack),
		.o_tx_req(tx_req),
		.i_tx_ack(tx_ack),
		.o_tx_data(tx_data)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_tx_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_req(tx_req),
		.i_data(tx_data),
		.o_ack(tx_ack),
		.o_tx(o_tx)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic o_clk
);

	// 8 ns period
	localparam realtime HALF_PERIOD = 4.0;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

endmodule

// ==== test/tb_uart_mon.sv ====
`timescale 1ns/1ps

module tb_uart_mon;

	import uart_mon_pkg::*;

	localparam int CLKS_PER_BIT  = 16;
	// longest reply is ten characters, generous margin on top
	localparam int REPLY_TIMEOUT = 40 * 10 * CLKS_PER_BIT;

	logic     clk;
	logic     i_reset;
	logic     i_rx;
	logic     o_tx;
	mem_adr_t o_ram_adr;
	word_t    o_ram_wdata;
	word_t    i_ram_rdata;
	logic     o_ram_wen;
	logic     o_cpu_start;
	logic     o_quit;
	mem_adr_t o_start_adr;

	word_t    mem [0:4095];
	word_t    exp_mem [0:4095];
	word_t    rd_pipe;
	byte_t    tx_chars [$];
	int       wen_count;
	int       start_count;
	int       quit_count;
	mem_adr_t last_wen_adr;
	word_t    last_wen_data;

	tb_clock tb_clock_inst (
		.o_clk(clk)
	);

	uart_mon_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_mon_top_inst (
		.clk(clk),
		.i_reset(i_reset),
		.i_rx(i_rx),
		.o_tx(o_tx),
		.o_ram_adr(o_ram_adr),
		.o_ram_wdata(o_ram_wdata),
		.i_ram_rdata(i_ram_rdata),
		.o_ram_wen(o_ram_wen),
		.o_cpu_start(o_cpu_start),
		.o_quit(o_quit),
		.o_start_adr(o_start_adr)
	);

	task automatic report_mismatch(input string msg);
		$display("Fail %0t ns: %s", $time, msg);
		$display("=== FAIL ===");
		$fatal(1, "wrong value seen");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("=== FAIL ===");
		$fatal(1, "wait expired");
	endtask

	// fixed hex text of a value, case chosen by the caller
	function automatic string hex_text(input word_t v, input int digits, input bit upper);
		string      s;
		int         i;
		logic [3:0] n;
		byte_t      c;
		s = "";
		for (i = digits - 1; i >= 0; i--) begin
			n = v[4 * i +: 4];
			if (n < 4'd10)
				c = 8'h30 + 8'(n);
			else if (upper)
				c = 8'h41 + 8'(n - 4'd10);
			else
				c = 8'h61 + 8'(n - 4'd10);
			s = $sformatf("%s%c", s, c);
		end
		return s;
	endfunction

	// memory fill, every address bit counts
	function automatic word_t fill_word(input int adr);
		return (32'(adr) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
	endfunction

	// one 8N1 frame, called on a falling edge
	task automatic send_byte(input byte_t b);
		int k;
		i_rx = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (k = 0; k < 8; k++) begin
			i_rx = b[k];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		i_rx = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic send_line(input string s);
		int i;
		for (i = 0; i < s.len(); i++)
			send_byte(byte_t'(s[i]));
		send_byte(CHAR_CR);
		send_byte(CHAR_LF);
	endtask

	// reply body, then CR LF
	task automatic expect_reply(input string body, input string what);
		int    n;
		int    t;
		int    i;
		byte_t got;
		byte_t want;
		n = body.len() + 2;
		t = 0;
		while (tx_chars.size() < n) begin
			@(negedge clk);
			t++;
			if (t > REPLY_TIMEOUT)
				report_timeout($sformatf("the reply to the %s command", what));
		end
		for (i = 0; i < n; i++) begin
			got = tx_chars.pop_front();
			if (i < body.len())
				want = byte_t'(body[i]);
			else if (i == body.len())
				want = CHAR_CR;
			else
				want = CHAR_LF;
			assert (got === want) else
				report_mismatch($sformatf("%s reply char %0d is %h, expected %h",
					what, i, got, want));
		end
	endtask

	task automatic write_word(input mem_adr_t adr, input word_t data);
		int wen_base;
		int start_base;
		wen_base   = wen_count;
		start_base = start_count;
		send_line({"w ", hex_text(word_t'(adr), 3, 1'b1), " ", hex_text(data, 8, 1'b1)});
		expect_reply("OK", "write");
		exp_mem[adr] = data;
		assert (wen_count - wen_base == 1) else
			report_mismatch($sformatf("write gave %0d ram strobes", wen_count - wen_base));
		assert (last_wen_adr === adr && last_wen_data === data) else
			report_mismatch($sformatf("write strobe carried %h/%h, expected %h/%h",
				last_wen_adr, last_wen_data, adr, data));
		assert (mem[adr] === data) else
			report_mismatch($sformatf("memory at %h holds %h after write", adr, mem[adr]));
		assert (start_count == start_base) else
			report_mismatch("write pulsed cpu start");
	endtask

	// lower case address, spaces padded around the field
	task automatic read_word(input mem_adr_t adr);
		int wen_base;
		wen_base = wen_count;
		send_line({"r   ", hex_text(word_t'(adr), 3, 1'b0), "  "});
		expect_reply(hex_text(exp_mem[adr], 8, 1'b1), "read");
		assert (wen_count == wen_base) else
			report_mismatch("read strobed ram write");
	endtask

	task automatic go_start(input logic [19:0] field);
		int start_base;
		start_base = start_count;
		send_line({"g ", hex_text(word_t'(field), 5, 1'b1)});
		expect_reply("OK", "go");
		assert (start_count - start_base == 1) else
			report_mismatch($sformatf("go gave %0d cpu start pulses", start_count - start_base));
		assert (o_start_adr === field[11:0]) else
			report_mismatch($sformatf("start address %h, expected %h", o_start_adr, field[11:0]));
	endtask

	task automatic quit_cmd();
		int quit_base;
		quit_base = quit_count;
		send_line("q");
		expect_reply("OK", "quit");
		assert (quit_count - quit_base == 1) else
			report_mismatch($sformatf("quit gave %0d quit pulses", quit_count - quit_base));
	endtask

	task automatic bad_line(input string s);
		int wen_base;
		int start_base;
		int quit_base;
		wen_base   = wen_count;
		start_base = start_count;
		quit_base  = quit_count;
		send_line(s);
		expect_reply("?", "malformed");
		assert (wen_count == wen_base && start_count == start_base && quit_count == quit_base)
			else report_mismatch({"malformed line '", s, "' touched the outputs"});
	endtask

	task automatic compare_memory();
		int k;
		for (k = 0; k < 4096; k++)
			assert (mem[k] === exp_mem[k]) else
				report_mismatch($sformatf("memory at %h holds %h, expected %h",
					k, mem[k], exp_mem[k]));
	endtask

	// ram model, one cycle read latency
	always @(negedge clk) begin
		if (o_ram_wen === 1'b1) begin
			mem[o_ram_adr] <= o_ram_wdata;
			wen_count      <= wen_count + 1;
			last_wen_adr   <= o_ram_adr;
			last_wen_data  <= o_ram_wdata;
		end
		if (o_cpu_start === 1'b1)
			start_count <= start_count + 1;
		if (o_quit === 1'b1)
			quit_count <= quit_count + 1;
		rd_pipe     <= mem[o_ram_adr];
		i_ram_rdata <= rd_pipe;
	end

	// decode o_tx frames into the character queue
	always @(negedge clk) begin : tx_decode
		int    k;
		byte_t ch;
		if (!i_reset && o_tx === 1'b0) begin
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			assert (o_tx === 1'b0) else
				report_mismatch("start bit on o_tx ended early");
			for (k = 0; k < 8; k++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				ch[k] = o_tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (o_tx === 1'b1) else
				report_mismatch("stop bit on o_tx is low");
			tx_chars.push_back(ch);
		end
	end

	a_start_quit_apart: assert property (@(posedge clk) disable iff (i_reset)
		!(o_cpu_start && o_quit))
		else report_mismatch("cpu start and quit high together");

	initial begin
		int          i;
		int unsigned seed;
		mem_adr_t    adr;
		word_t       data;
		logic [19:0] field;
		seed = $urandom(32'h3b88);
		i_reset     = 1'b1;
		i_rx        = 1'b1;
		i_ram_rdata = '0;
		rd_pipe     = '0;
		wen_count   = 0;
		start_count = 0;
		quit_count  = 0;
		for (i = 0; i < 4096; i++) begin
			mem[i]     = fill_word(i);
			exp_mem[i] = fill_word(i);
		end
		repeat (5) @(negedge clk);
		i_reset = 1'b0;
		@(negedge clk);

		// idle outputs after reset
		assert (o_tx === 1'b1) else
			report_mismatch("o_tx is not high after reset");
		assert (o_ram_wen === 1'b0 && o_cpu_start === 1'b0 && o_quit === 1'b0) else
			report_mismatch("a strobe is high after reset");
		assert (o_start_adr === '0) else
			report_mismatch($sformatf("start address %h after reset", o_start_adr));

		for (i = 0; i < 3; i++) begin
			adr  = 12'($urandom);
			data = $urandom;
			write_word(adr, data);
		end

		// words placed straight into the model, read back over serial
		for (i = 0; i < 4; i++) begin
			adr          = (i == 0) ? 12'hfed : 12'($urandom);
			data         = $urandom;
			mem[adr]     = data;
			exp_mem[adr] = data;
			read_word(adr);
		end

		field = 20'($urandom);
		go_start(field);
		quit_cmd();

		bad_line("x 12");
		bad_line("w 1G0 5");
		bad_line("r");
		bad_line("w 10");
		compare_memory();

		// each command goes out right after the previous LF
		adr  = 12'($urandom);
		data = $urandom;
		write_word(adr, data);
		read_word(adr);
		write_word(adr + 12'd1, ~data);
		field = 20'($urandom);
		go_start(field);
		read_word(adr + 12'd1);
		bad_line("r 1 2");
		quit_cmd();
		compare_memory();

		// the line stays idle after the last reply
		repeat (2 * 10 * CLKS_PER_BIT) @(negedge clk);
		assert (tx_chars.size() == 0 && o_tx === 1'b1) else
			report_mismatch("characters sent after the last reply");

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== sim.f ====
hdl/uart_mon_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/mon_cmd_parser.sv
hdl/mon_mem_access.sv
hdl/mon_reply.sv
hdl/uart_mon_top.sv
test/tb_clock.sv
test/tb_uart_mon.sv
